// File: vga_testdata.txt
// One frame per line: rectangle xpos, ypos and expected count of rectangle pixels
// All columns in hex
002 002 00c
00e 008 004
014 000 000
000 000 00c
005 006 00c
00f 009 001

// File: filelist.f
vga_pkg.sv
draw_pkg.sv
vga_timing.sv
draw_background.sv
draw_rect.sv
vga_top.sv
vga_tb.sv

// File: Bender.yml
package:
  name: vga_subsystem

sources:
  - files:
      - vga_pkg.sv
      - draw_pkg.sv
      - vga_timing.sv
      - draw_background.sv
      - draw_rect.sv
      - vga_top.sv
  - target: simulation
    files:
      - vga_tb.sv

// File: vga_tb.sv
/*
 * Self-checking testbench for the VGA subsystem.
 * Reads one rectangle position per frame from the data file, models the
 * raster and checks sync, every output pixel and the rectangle pixel count.
 */

`timescale 1ns/1ps
`default_nettype none

module vga_tb
        import vga_pkg::*;
        import draw_pkg::*;
();

        localparam int H_ACTIVE   = 16;
        localparam int H_FRONT    = 2;
        localparam int H_SYNC     = 3;
        localparam int H_BACK     = 3;
        localparam int V_ACTIVE   = 10;
        localparam int V_FRONT    = 1;
        localparam int V_SYNC     = 2;
        localparam int V_BACK     = 1;
        localparam int RECT_W     = 4;
        localparam int RECT_H     = 3;
        localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
        localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
        localparam int NUM_FRAMES = 6;
        localparam int DRIVE_DLY  = 2;

        logic pclk;
        logic rst;
        pos_t xpos;
        pos_t ypos;
        logic hsync;
        logic vsync;
        rgb_t rgb;

        // Three words per frame: xpos, ypos, expected rectangle pixels
        logic [POS_W-1:0] test_mem [0:3*NUM_FRAMES-1];
        logic [31:0]      lfsr_state;

        vga_top #(
                .H_ACTIVE (H_ACTIVE),
                .H_FRONT  (H_FRONT),
                .H_SYNC   (H_SYNC),
                .H_BACK   (H_BACK),
                .V_ACTIVE (V_ACTIVE),
                .V_FRONT  (V_FRONT),
                .V_SYNC   (V_SYNC),
                .V_BACK   (V_BACK),
                .RECT_W   (RECT_W),
                .RECT_H   (RECT_H)
        ) u_vga_top (
                .pclk  (pclk),
                .rst   (rst),
                .xpos  (xpos),
                .ypos  (ypos),
                .hsync (hsync),
                .vsync (vsync),
                .rgb   (rgb)
        );

        always #20 pclk = ~pclk;

        task automatic stop_on_error();
                $display("Something failed");
                $fatal(1, "stopping at the first error");
        endtask

        task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
                if (got !== exp) begin
                        $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
                        stop_on_error();
                end
        endtask

        task automatic check_level(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("MISMATCH at %0t: %s, got %b expected %b", $time, what, got, exp);
                        stop_on_error();
                end
        endtask

        task automatic check_count(input int got, input int exp, input string what);
                if (got != exp) begin
                        $display("MISMATCH at %0t: %s, got %0d expected %0d", $time, what, got, exp);
                        stop_on_error();
                end
        endtask

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                if (s[0]) begin
                        return (s >> 1) ^ 32'h8020_0003;
                end
                return s >> 1;
        endfunction

        // One LFSR step for every bit taken
        task automatic rand_bits(input int n, output pos_t val);
                val = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        val = {val[POS_W-2:0], lfsr_state[0]};
                end
        endtask

        // Expected colour of output pixel (h,v) with the rectangle at (rx,ry)
        function automatic rgb_t expected_rgb(input int h, input int v, input int rx, input int ry);
                if (h >= H_ACTIVE || v >= V_ACTIVE) return COL_BLACK;
                if (h >= rx && h < rx + RECT_W && v >= ry && v < ry + RECT_H) return COL_RECT;
                if (v == 0) return COL_YELLOW;
                if (v == V_ACTIVE - 1) return COL_RED;
                if (h == 0) return COL_GREEN;
                if (h == H_ACTIVE - 1) return COL_BLUE;
                return COL_GREY;
        endfunction

        task automatic next_cycle();
                @(posedge pclk);
                #DRIVE_DLY;
        endtask

        initial begin
                int    rx;
                int    ry;
                int    rect_pix;
                string where;

                pclk = 1'b0;
                rst = 1'b1;
                lfsr_state = 32'hbb6a9ee0;
                $readmemh("vga_testdata.txt", test_mem);
                for (int i = 0; i < 3*NUM_FRAMES; i++) begin
                        if ($isunknown(test_mem[i])) begin
                                $display("Test data file is missing or has too few entries");
                                stop_on_error();
                        end
                end
                xpos = test_mem[0];
                ypos = test_mem[1];

                repeat (4) begin
                        next_cycle();
                        check_level(hsync, 1'b0, "hsync during reset");
                        check_level(vsync, 1'b0, "vsync during reset");
                end
                rst = 1'b0;

                // Pipeline fill, two cycles before pixel (0,0) shows
                check_level(hsync, 1'b0, "hsync in first cycle after reset");
                check_level(vsync, 1'b0, "vsync in first cycle after reset");
                next_cycle();
                check_level(hsync, 1'b0, "hsync in second cycle after reset");
                check_level(vsync, 1'b0, "vsync in second cycle after reset");

                for (int f = 0; f < NUM_FRAMES; f++) begin
                        rx = int'(test_mem[3*f]);
                        ry = int'(test_mem[3*f+1]);
                        rect_pix = 0;
                        for (int v = 0; v < V_TOTAL; v++) begin
                                for (int h = 0; h < H_TOTAL; h++) begin
                                        next_cycle();
                                        where = $sformatf("frame %0d pixel (%0d,%0d)", f, h, v);
                                        check_level(hsync, (h >= H_ACTIVE + H_FRONT) &&
                                                (h < H_ACTIVE + H_FRONT + H_SYNC), {"hsync ", where});
                                        check_level(vsync, (v >= V_ACTIVE + V_FRONT) &&
                                                (v < V_ACTIVE + V_FRONT + V_SYNC), {"vsync ", where});
                                        check_rgb(rgb, expected_rgb(h, v, rx, ry), {"rgb ", where});
                                        if (rgb == COL_RECT) begin
                                                rect_pix++;
                                        end
                                        // Mid-frame change, must wait for the next frame start
                                        if (h == H_ACTIVE/2 && v == V_ACTIVE/2) begin
                                                if (f % 2 == 0) begin
                                                        rand_bits(4, xpos);
                                                        rand_bits(4, ypos);
                                                end else if (f + 1 < NUM_FRAMES) begin
                                                        xpos = test_mem[3*f+3];
                                                        ypos = test_mem[3*f+4];
                                                end
                                        end
                                        // Next frame's position during vertical blanking
                                        if (h == 0 && v == V_ACTIVE && f + 1 < NUM_FRAMES) begin
                                                xpos = test_mem[3*f+3];
                                                ypos = test_mem[3*f+4];
                                        end
                                end
                        end
                        check_count(rect_pix, int'(test_mem[3*f+2]),
                                $sformatf("rectangle pixels in frame %0d", f));
                end

                $display("Everything OK");
                $finish;
        end

endmodule

`default_nettype wire

// File: vga_top.sv
/*
 * VGA subsystem top level.
 * Timing generator, background stage and rectangle stage in a chain.
 */

`timescale 1ns/1ps
`default_nettype none

module vga_top
        import vga_pkg::*;
        import draw_pkg::*;
#(
        parameter int H_ACTIVE = DEF_H_ACTIVE,
        parameter int H_FRONT  = DEF_H_FRONT,
        parameter int H_SYNC   = DEF_H_SYNC,
        parameter int H_BACK   = DEF_H_BACK,
        parameter int V_ACTIVE = DEF_V_ACTIVE,
        parameter int V_FRONT  = DEF_V_FRONT,
        parameter int V_SYNC   = DEF_V_SYNC,
        parameter int V_BACK   = DEF_V_BACK,
        parameter int RECT_W   = DEF_RECT_W,
        parameter int RECT_H   = DEF_RECT_H
) (
        input  logic pclk,
        input  logic rst,
        input  pos_t xpos,
        input  pos_t ypos,
        output logic hsync,
        output logic vsync,
        output rgb_t rgb
);

        // Raster position straight from the counters
        pos_t tim_hcount;
        pos_t tim_vcount;
        logic tim_hsync;
        logic tim_vsync;
        logic tim_hblnk;
        logic tim_vblnk;

        // One cycle later, with background colour
        pos_t bg_hcount;
        pos_t bg_vcount;
        logic bg_hsync;
        logic bg_vsync;
        logic bg_hblnk;
        logic bg_vblnk;
        rgb_t bg_rgb;

        vga_timing #(
                .H_ACTIVE (H_ACTIVE),
                .H_FRONT  (H_FRONT),
                .H_SYNC   (H_SYNC),
                .H_BACK   (H_BACK),
                .V_ACTIVE (V_ACTIVE),
                .V_FRONT  (V_FRONT),
                .V_SYNC   (V_SYNC),
                .V_BACK   (V_BACK)
        ) u_vga_timing (
                .pclk   (pclk),
                .rst    (rst),
                .hcount (tim_hcount),
                .vcount (tim_vcount),
                .hsync  (tim_hsync),
                .vsync  (tim_vsync),
                .hblnk  (tim_hblnk),
                .vblnk  (tim_vblnk)
        );

        draw_background #(
                .H_ACTIVE (H_ACTIVE),
                .V_ACTIVE (V_ACTIVE)
        ) u_draw_background (
                .pclk       (pclk),
                .rst        (rst),
                .hcount_in  (tim_hcount),
                .vcount_in  (tim_vcount),
                .hsync_in   (tim_hsync),
                .vsync_in   (tim_vsync),
                .hblnk_in   (tim_hblnk),
                .vblnk_in   (tim_vblnk),
                .hcount_out (bg_hcount),
                .vcount_out (bg_vcount),
                .hsync_out  (bg_hsync),
                .vsync_out  (bg_vsync),
                .hblnk_out  (bg_hblnk),
                .vblnk_out  (bg_vblnk),
                .rgb        (bg_rgb)
        );

        // Last stage, only sync and colour leave the chip
        draw_rect #(
                .RECT_W (RECT_W),
                .RECT_H (RECT_H)
        ) u_draw_rect (
                .pclk       (pclk),
                .rst        (rst),
                .xpos       (xpos),
                .ypos       (ypos),
                .hcount_in  (bg_hcount),
                .vcount_in  (bg_vcount),
                .hsync_in   (bg_hsync),
                .vsync_in   (bg_vsync),
                .hblnk_in   (bg_hblnk),
                .vblnk_in   (bg_vblnk),
                .rgb_in     (bg_rgb),
                .hcount_out (),
                .vcount_out (),
                .hsync_out  (hsync),
                .vsync_out  (vsync),
                .hblnk_out  (),
                .vblnk_out  (),
                .rgb        (rgb)
        );

endmodule

`default_nettype wire

// File: draw_rect.sv
/*
 * Rectangle overlay stage.
 * Draws a fixed-size rectangle at a position sampled once per frame.
 * Timing signals pass through with one cycle of delay.
 */

`timescale 1ns/1ps
`default_nettype none

module draw_rect
        import vga_pkg::*;
        import draw_pkg::*;
#(
        parameter int RECT_W = DEF_RECT_W,
        parameter int RECT_H = DEF_RECT_H
) (
        input  logic pclk,
        input  logic rst,

        input  pos_t xpos,
        input  pos_t ypos,

        input  pos_t hcount_in,
        input  pos_t vcount_in,
        input  logic hsync_in,
        input  logic vsync_in,
        input  logic hblnk_in,
        input  logic vblnk_in,
        input  rgb_t rgb_in,

        output pos_t hcount_out,
        output pos_t vcount_out,
        output logic hsync_out,
        output logic vsync_out,
        output logic hblnk_out,
        output logic vblnk_out,
        output rgb_t rgb
);

        // One extra bit so the far edge cannot wrap
        localparam logic [POS_W:0] RECT_W_EXT = (POS_W+1)'(RECT_W);
        localparam logic [POS_W:0] RECT_H_EXT = (POS_W+1)'(RECT_H);

        pos_t           x_latched;
        pos_t           y_latched;
        pos_t           x_cur;
        pos_t           y_cur;
        logic           frame_start;
        logic [POS_W:0] x_end;
        logic [POS_W:0] y_end;
        logic           in_rect;
        rgb_t           rgb_nxt;

        always_comb begin
                frame_start = (hcount_in == '0) && (vcount_in == '0);

                // Pixel (0,0) already uses the position sampled for its frame
                x_cur = frame_start ? xpos : x_latched;
                y_cur = frame_start ? ypos : y_latched;

                x_end = {1'b0, x_cur} + RECT_W_EXT;
                y_end = {1'b0, y_cur} + RECT_H_EXT;

                in_rect = (hcount_in >= x_cur) && ({1'b0, hcount_in} < x_end) &&
                          (vcount_in >= y_cur) && ({1'b0, vcount_in} < y_end);

                // Blanking clips whatever part falls outside the active area
                if (in_rect && !hblnk_in && !vblnk_in) begin
                        rgb_nxt = COL_RECT;
                end else begin
                        rgb_nxt = rgb_in;
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        x_latched <= '0;
                        y_latched <= '0;
                end else if (frame_start) begin
                        x_latched <= xpos;
                        y_latched <= ypos;
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        hcount_out <= '0;
                        vcount_out <= '0;
                        hsync_out  <= 1'b0;
                        vsync_out  <= 1'b0;
                        hblnk_out  <= 1'b0;
                        vblnk_out  <= 1'b0;
                        rgb        <= '0;
                end else begin
                        hcount_out <= hcount_in;
                        vcount_out <= vcount_in;
                        hsync_out  <= hsync_in;
                        vsync_out  <= vsync_in;
                        hblnk_out  <= hblnk_in;
                        vblnk_out  <= vblnk_in;
                        rgb        <= rgb_nxt;
                end
        end

        // Relies on the background stage blacking out the blanking interval
        a_black_in_blank: assert property (@(posedge pclk) disable iff (rst)
                (hblnk_out || vblnk_out) |-> (rgb == COL_BLACK))
                else $error("non-black colour during blanking");

endmodule

`default_nettype wire

// File: draw_background.sv
/*
 * Background drawing stage.
 * Grey field with a one-pixel coloured frame, black during blanking.
 * Timing signals pass through with one cycle of delay.
 */

`timescale 1ns/1ps
`default_nettype none

module draw_background
        import vga_pkg::*;
        import draw_pkg::*;
#(
        parameter int H_ACTIVE = DEF_H_ACTIVE,
        parameter int V_ACTIVE = DEF_V_ACTIVE
) (
        input  logic pclk,
        input  logic rst,

        input  pos_t hcount_in,
        input  pos_t vcount_in,
        input  logic hsync_in,
        input  logic vsync_in,
        input  logic hblnk_in,
        input  logic vblnk_in,

        output pos_t hcount_out,
        output pos_t vcount_out,
        output logic hsync_out,
        output logic vsync_out,
        output logic hblnk_out,
        output logic vblnk_out,
        output rgb_t rgb
);

        // Last visible column and row
        localparam pos_t X_LAST = pos_t'(H_ACTIVE - 1);
        localparam pos_t Y_LAST = pos_t'(V_ACTIVE - 1);

        rgb_t rgb_nxt;

        // Top and bottom lines win over the side columns at the corners
        always_comb begin
                if (hblnk_in || vblnk_in) begin
                        rgb_nxt = COL_BLACK;
                end else if (vcount_in == '0) begin
                        rgb_nxt = COL_YELLOW;
                end else if (vcount_in == Y_LAST) begin
                        rgb_nxt = COL_RED;
                end else if (hcount_in == '0) begin
                        rgb_nxt = COL_GREEN;
                end else if (hcount_in == X_LAST) begin
                        rgb_nxt = COL_BLUE;
                end else begin
                        rgb_nxt = COL_GREY;
                end
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        hcount_out <= '0;
                        vcount_out <= '0;
                        hsync_out  <= 1'b0;
                        vsync_out  <= 1'b0;
                        hblnk_out  <= 1'b0;
                        vblnk_out  <= 1'b0;
                        rgb        <= '0;
                end else begin
                        hcount_out <= hcount_in;
                        vcount_out <= vcount_in;
                        hsync_out  <= hsync_in;
                        vsync_out  <= vsync_in;
                        hblnk_out  <= hblnk_in;
                        vblnk_out  <= vblnk_in;
                        rgb        <= rgb_nxt;
                end
        end

endmodule

`default_nettype wire

// File: vga_timing.sv
/*
 * Raster timing generator.
 * Pixel and line counters with registered sync and blanking levels.
 */

`timescale 1ns/1ps
`default_nettype none

module vga_timing
        import vga_pkg::*;
#(
        parameter int H_ACTIVE = DEF_H_ACTIVE,
        parameter int H_FRONT  = DEF_H_FRONT,
        parameter int H_SYNC   = DEF_H_SYNC,
        parameter int H_BACK   = DEF_H_BACK,
        parameter int V_ACTIVE = DEF_V_ACTIVE,
        parameter int V_FRONT  = DEF_V_FRONT,
        parameter int V_SYNC   = DEF_V_SYNC,
        parameter int V_BACK   = DEF_V_BACK
) (
        input  logic pclk,
        input  logic rst,
        output pos_t hcount,
        output pos_t vcount,
        output logic hsync,
        output logic vsync,
        output logic hblnk,
        output logic vblnk
);

        localparam int   H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
        localparam int   V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
        localparam pos_t H_LAST     = pos_t'(H_TOTAL - 1);
        localparam pos_t V_LAST     = pos_t'(V_TOTAL - 1);
        localparam pos_t H_BLNK_BEG = pos_t'(H_ACTIVE);
        localparam pos_t V_BLNK_BEG = pos_t'(V_ACTIVE);
        localparam pos_t H_SYNC_BEG = pos_t'(H_ACTIVE + H_FRONT);
        localparam pos_t V_SYNC_BEG = pos_t'(V_ACTIVE + V_FRONT);
        localparam pos_t H_SYNC_END = pos_t'(H_ACTIVE + H_FRONT + H_SYNC);
        localparam pos_t V_SYNC_END = pos_t'(V_ACTIVE + V_FRONT + V_SYNC);

        pos_t hcount_nxt;
        pos_t vcount_nxt;
        logic hsync_nxt;
        logic vsync_nxt;
        logic hblnk_nxt;
        logic vblnk_nxt;

        // Next position, then levels decoded from it so all outputs stay aligned
        always_comb begin
                if (hcount == H_LAST) begin
                        hcount_nxt = '0;
                        if (vcount == V_LAST) begin
                                vcount_nxt = '0;
                        end else begin
                                vcount_nxt = vcount + 1'b1;
                        end
                end else begin
                        hcount_nxt = hcount + 1'b1;
                        vcount_nxt = vcount;
                end

                hblnk_nxt = (hcount_nxt >= H_BLNK_BEG);
                vblnk_nxt = (vcount_nxt >= V_BLNK_BEG);
                hsync_nxt = (hcount_nxt >= H_SYNC_BEG) && (hcount_nxt < H_SYNC_END);
                vsync_nxt = (vcount_nxt >= V_SYNC_BEG) && (vcount_nxt < V_SYNC_END);
        end

        always_ff @(posedge pclk) begin
                if (rst) begin
                        hcount <= '0;
                        vcount <= '0;
                        hsync  <= 1'b0;
                        vsync  <= 1'b0;
                        hblnk  <= 1'b0;
                        vblnk  <= 1'b0;
                end else begin
                        hcount <= hcount_nxt;
                        vcount <= vcount_nxt;
                        hsync  <= hsync_nxt;
                        vsync  <= vsync_nxt;
                        hblnk  <= hblnk_nxt;
                        vblnk  <= vblnk_nxt;
                end
        end

        // Counter wraps before reaching the line total
        a_hcount_range: assert property (@(posedge pclk) disable iff (rst)
                hcount <= H_LAST)
                else $error("hcount ran past the end of the line");

        // Sync pulse sits inside the blanking interval
        a_hsync_in_blank: assert property (@(posedge pclk) disable iff (rst)
                hsync |-> hblnk)
                else $error("hsync asserted outside horizontal blanking");

endmodule

`default_nettype wire

// File: draw_pkg.sv
/*
 * Drawing definitions for the VGA subsystem.
 * Colour type, palette constants and default rectangle size.
 */

`default_nettype none

package draw_pkg;

        // 12-bit colour, red in the top nibble and blue in the bottom
        typedef struct packed {
                logic [3:0] r;
                logic [3:0] g;
                logic [3:0] b;
        } rgb_t;

        localparam rgb_t COL_BLACK  = 12'h0_0_0;
        localparam rgb_t COL_GREY   = 12'h8_8_8;
        localparam rgb_t COL_YELLOW = 12'hf_f_0;
        localparam rgb_t COL_RED    = 12'hf_0_0;
        localparam rgb_t COL_GREEN  = 12'h0_f_0;
        localparam rgb_t COL_BLUE   = 12'h0_0_f;
        // Rectangle fill, kept distinct from the border colours
        localparam rgb_t COL_RECT   = 12'hf_8_c;

        // Rectangle size in pixels and lines
        localparam int DEF_RECT_W = 48;
        localparam int DEF_RECT_H = 64;

endpackage

`default_nettype wire

// File: vga_pkg.sv
/*
 * Raster timing definitions shared by the VGA subsystem.
 * Position width and type, plus default 1024x768 timing values.
 */

`default_nettype none

package vga_pkg;

        // Width of every position counter and position port
        localparam int POS_W = 12;

        typedef logic [POS_W-1:0] pos_t;

        // Horizontal timing in pixels, total 1344
        localparam int DEF_H_ACTIVE = 1024;
        localparam int DEF_H_FRONT  = 24;
        localparam int DEF_H_SYNC   = 136;
        localparam int DEF_H_BACK   = 160;

        // Vertical timing in lines, total 806
        localparam int DEF_V_ACTIVE = 768;
        localparam int DEF_V_FRONT  = 3;
        localparam int DEF_V_SYNC   = 6;
        localparam int DEF_V_BACK   = 29;

endpackage

`default_nettype wire
